// ==== include/bus_settings.svh ====
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

// Bus widths
`define BUS_ADDR_W 32
`define BUS_DATA_W 32

// Word RAM, indexed by address bits [9:2]
`define RAM_WORDS 256
`define RAM_WAIT 2 // Extra edges before RAM ready

// Address bit 16 high selects the I/O block
`define IO_SEL_BIT 16

// Scratch registers in the I/O block
`define IO_REGS 4

`endif

// ==== logic/bus_pkg.sv ====
`default_nettype none

`include "bus_settings.svh"

package bus_pkg;

	// Plain vector types for the bus fields
	typedef logic [`BUS_ADDR_W-1:0] bus_addr_t; // Byte address
	typedef logic [`BUS_DATA_W-1:0] bus_data_t; // Data word

	// Request carried from a port to a slave
	typedef struct packed {
		logic      rw;    // 1 = write
		bus_addr_t addr;
		bus_data_t wdata;
	} bus_req_t;

	// Reply from a slave
	typedef struct packed {
		logic      ready; // Held until the strobe falls
		bus_data_t rdata;
	} bus_rsp_t;

	// Arbiter FSM
	typedef enum logic [1:0] {
		ARB_IDLE,    // Wait for a port request
		ARB_WAIT_B,  // Port B owns the bus
		ARB_WAIT_C,  // Port C owns the bus
		ARB_RELEASE  // Wait for slave ready to clear
	} arb_state_t;

endpackage

`default_nettype wire

// ==== logic/dual_port_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module dual_port_arbiter
	import bus_pkg::*;
(
	input  wire logic     i_clock,
	input  wire logic     i_reset,

	// Port B, fixed winner
	input  wire logic     i_pb_request,
	input  wire bus_req_t i_pb_req,
	output logic          o_pb_ready,
	output bus_data_t     o_pb_rdata,

	// Port C
	input  wire logic     i_pc_request,
	input  wire bus_req_t i_pc_req,
	output logic          o_pc_ready,
	output bus_data_t     o_pc_rdata,

	// Internal bus
	output logic          o_bus_request,
	output bus_req_t      o_bus_req,
	input  wire bus_rsp_t i_bus_rsp
);

	arb_state_t state;

	logic pb_grant;
	logic pc_grant;
	logic pb_done;
	logic pc_done;

	// B wins when both ports ask in the same cycle
	assign pb_grant = (state == ARB_IDLE) && i_pb_request;
	assign pc_grant = (state == ARB_IDLE) && !i_pb_request && i_pc_request;

	// Slave has answered the current owner
	assign pb_done = (state == ARB_WAIT_B) && i_bus_rsp.ready;
	assign pc_done = (state == ARB_WAIT_C) && i_bus_rsp.ready;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state         <= ARB_IDLE;
			o_bus_request <= 1'b0;
			o_pb_ready    <= 1'b0;
			o_pc_ready    <= 1'b0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (pb_grant) begin
						o_bus_request <= 1'b1;
						state         <= ARB_WAIT_B;
					end else if (pc_grant) begin
						o_bus_request <= 1'b1;
						state         <= ARB_WAIT_C;
					end
				end

				// No timeout, the slave may stall as long as it likes
				ARB_WAIT_B: begin
					if (pb_done) begin
						o_bus_request <= 1'b0;
						o_pb_ready    <= 1'b1; // One cycle pulse
						state         <= ARB_RELEASE;
					end
				end

				ARB_WAIT_C: begin
					if (pc_done) begin
						o_bus_request <= 1'b0;
						o_pc_ready    <= 1'b1;
						state         <= ARB_RELEASE;
					end
				end

				ARB_RELEASE: begin
					o_pb_ready <= 1'b0;
					o_pc_ready <= 1'b0;
					if (!i_bus_rsp.ready)
						state <= ARB_IDLE; // Slave has let go
				end

				default: state <= ARB_IDLE;
			endcase
		end
	end

	// Request latched at grant, held for the whole transfer
	always_ff @(posedge i_clock) begin
		if (pb_grant)
			o_bus_req <= i_pb_req;
		else if (pc_grant)
			o_bus_req <= i_pc_req;
	end

	// Read data captured with the ready pulse
	always_ff @(posedge i_clock) begin
		if (pb_done)
			o_pb_rdata <= i_bus_rsp.rdata;
		if (pc_done)
			o_pc_rdata <= i_bus_rsp.rdata;
	end

endmodule

`default_nettype wire

// ==== logic/bus_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bus_settings.svh"

module bus_decoder
	import bus_pkg::*;
(
	// From the arbiter
	input  wire logic     i_bus_request,
	input  wire bus_req_t i_bus_req,
	output bus_rsp_t      o_bus_rsp,

	// RAM slave
	output logic          o_ram_request,
	output bus_req_t      o_ram_req,
	input  wire bus_rsp_t i_ram_rsp,

	// I/O register slave
	output logic          o_io_request,
	output bus_req_t      o_io_req,
	input  wire bus_rsp_t i_io_rsp
);

	logic io_sel;

	// Address is held by the arbiter until the next grant,
	// so the select stays put through release as well
	assign io_sel = i_bus_req.addr[`IO_SEL_BIT];

	// Only the selected slave sees the strobe
	assign o_ram_request = i_bus_request && !io_sel;
	assign o_io_request  = i_bus_request && io_sel;

	// Payload goes to both, harmless without the strobe
	assign o_ram_req = i_bus_req;
	assign o_io_req  = i_bus_req;

	// Reply comes only from the addressed slave
	always_comb begin
		if (io_sel)
			o_bus_rsp = i_io_rsp;
		else
			o_bus_rsp = i_ram_rsp;
	end

endmodule

`default_nettype wire

// ==== logic/ram_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bus_settings.svh"

module ram_slave
	import bus_pkg::*;
(
	input  wire logic     i_clock,
	input  wire logic     i_reset,
	input  wire logic     i_request,
	input  wire bus_req_t i_req,
	output bus_rsp_t      o_rsp
);

	localparam int RAM_AW = $clog2(`RAM_WORDS);
	localparam int WAIT_W = $clog2(`RAM_WAIT + 2);

	bus_data_t mem [`RAM_WORDS];

	logic [RAM_AW-1:0] index;
	logic [WAIT_W-1:0] wait_count;
	logic              ready;
	bus_data_t         rdata;
	logic              fire;

	// Word index where the upper region bits alias
	assign index = i_req.addr[RAM_AW+1:2];

	// Access once the last wait state is done
	assign fire = i_request && !ready && (wait_count == `RAM_WAIT);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			ready      <= 1'b0;
			wait_count <= '0;
		end else if (ready) begin
			if (!i_request) begin // Release once the strobe is gone
				ready      <= 1'b0;
				wait_count <= '0;
			end
		end else if (i_request) begin
			if (fire)
				ready <= 1'b1;
			else
				wait_count <= wait_count + 1'b1;
		end
	end

	// Word access on the edge where ready rises
	always_ff @(posedge i_clock) begin
		if (fire) begin
			if (i_req.rw)
				mem[index] <= i_req.wdata;
			rdata <= mem[index]; // Old word on a write
		end
	end

	assign o_rsp.ready = ready;
	assign o_rsp.rdata = rdata;

endmodule

`default_nettype wire

// ==== logic/io_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bus_settings.svh"

module io_regs
	import bus_pkg::*;
(
	input  wire logic     i_clock,
	input  wire logic     i_reset,
	input  wire logic     i_request,
	input  wire bus_req_t i_req,
	output bus_rsp_t      o_rsp
);

	localparam int          REG_AW  = $clog2(`IO_REGS);
	localparam logic [2:0]  CNT_OFS = 3'd4; // Write counter at 0x10

	bus_data_t scratch [`IO_REGS];
	bus_data_t wr_count;
	bus_data_t rd_value;
	bus_data_t rdata;
	logic      ready;
	logic      accept;
	logic [2:0] offset;

	assign offset = i_req.addr[4:2];
	assign accept = i_request && !ready; // Answer on the first edge

	// Read mux, unused offsets give zero
	always_comb begin
		if (offset < `IO_REGS)
			rd_value = scratch[offset[REG_AW-1:0]];
		else if (offset == CNT_OFS)
			rd_value = wr_count;
		else
			rd_value = '0;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			ready    <= 1'b0;
			wr_count <= '0;
			for (int i = 0; i < `IO_REGS; i++)
				scratch[i] <= '0;
		end else if (accept) begin
			ready <= 1'b1;
			if (i_req.rw) begin
				wr_count <= wr_count + 1'b1; // Any offset counts
				if (offset < `IO_REGS)
					scratch[offset[REG_AW-1:0]] <= i_req.wdata;
			end
		end else if (ready && !i_request) begin
			ready <= 1'b0;
		end
	end

	// Value before the write lands
	always_ff @(posedge i_clock) begin
		if (accept)
			rdata <= rd_value;
	end

	assign o_rsp.ready = ready;
	assign o_rsp.rdata = rdata;

endmodule

`default_nettype wire

// ==== logic/bus_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_subsystem
	import bus_pkg::*;
(
	input  wire logic     i_clock,
	input  wire logic     i_reset,

	// Port B
	input  wire logic     i_pb_request,
	input  wire bus_req_t i_pb_req,
	output logic          o_pb_ready,
	output bus_data_t     o_pb_rdata,

	// Port C
	input  wire logic     i_pc_request,
	input  wire bus_req_t i_pc_req,
	output logic          o_pc_ready,
	output bus_data_t     o_pc_rdata
);

	// Arbiter to decoder
	logic     bus_request;
	bus_req_t bus_req;
	bus_rsp_t bus_rsp;

	// Decoder to slaves
	logic     ram_request;
	bus_req_t ram_req;
	bus_rsp_t ram_rsp;
	logic     io_request;
	bus_req_t io_req;
	bus_rsp_t io_rsp;

	dual_port_arbiter u_arbiter (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_pb_request  (i_pb_request),
		.i_pb_req      (i_pb_req),
		.o_pb_ready    (o_pb_ready),
		.o_pb_rdata    (o_pb_rdata),
		.i_pc_request  (i_pc_request),
		.i_pc_req      (i_pc_req),
		.o_pc_ready    (o_pc_ready),
		.o_pc_rdata    (o_pc_rdata),
		.o_bus_request (bus_request),
		.o_bus_req     (bus_req),
		.i_bus_rsp     (bus_rsp)
	);

	bus_decoder u_decoder (
		.i_bus_request (bus_request),
		.i_bus_req     (bus_req),
		.o_bus_rsp     (bus_rsp),
		.o_ram_request (ram_request),
		.o_ram_req     (ram_req),
		.i_ram_rsp     (ram_rsp),
		.o_io_request  (io_request),
		.o_io_req      (io_req),
		.i_io_rsp      (io_rsp)
	);

	ram_slave u_ram (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_request (ram_request),
		.i_req     (ram_req),
		.o_rsp     (ram_rsp)
	);

	io_regs u_io (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_request (io_request),
		.i_req     (io_req),
		.o_rsp     (io_rsp)
	);

endmodule

`default_nettype wire

// ==== sim/clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
	output logic o_clock,
	output logic o_reset
);

	localparam int HALF_PERIOD  = 5; // 10 ns clock
	localparam int RESET_CYCLES = 16;

	initial begin
		o_clock = 1'b0;
		forever #HALF_PERIOD o_clock = ~o_clock;
	end

	// Reset falls on the negedge after the 16th rising edge
	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clock);
		@(negedge o_clock);
		o_reset = 1'b0;
	end

endmodule

`default_nettype wire

// ==== sim/bus_subsystem_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_subsystem_sva
	import bus_pkg::*;
(
	input wire logic     i_clock,
	input wire logic     i_reset,
	input wire logic     i_pb_ready,
	input wire logic     i_pc_ready,
	input wire logic     i_bus_request,
	input wire bus_req_t i_bus_req,
	input wire bus_rsp_t i_bus_rsp
);

	// Port ready is a one cycle pulse
	pb_ready_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
		i_pb_ready |=> !i_pb_ready)
		else $error("Port B ready high for two cycles in a row");

	pc_ready_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
		i_pc_ready |=> !i_pc_ready)
		else $error("Port C ready high for two cycles in a row");

	ready_exclusive: assert property (@(posedge i_clock) disable iff (i_reset)
		!(i_pb_ready && i_pc_ready))
		else $error("Both port readies high in the same cycle");

	// Strobe and payload frozen until the slave answers
	bus_req_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus_request && !i_bus_rsp.ready |=> i_bus_request && $stable(i_bus_req))
		else $error("Bus request changed before slave ready");

endmodule

bind bus_subsystem bus_subsystem_sva u_sva (
	.i_clock       (i_clock),
	.i_reset       (i_reset),
	.i_pb_ready    (o_pb_ready),
	.i_pc_ready    (o_pc_ready),
	.i_bus_request (bus_request),
	.i_bus_req     (bus_req),
	.i_bus_rsp     (bus_rsp)
);

`default_nettype wire

// ==== sim/bus_subsystem_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bus_settings.svh"

module bus_subsystem_tb
	import bus_pkg::*;
();

	localparam bus_addr_t IO_BASE    = 32'h1 << `IO_SEL_BIT;
	localparam int        COUNT_OFS  = 4;   // Write counter at 0x10
	localparam int        N_RAND     = 120; // Per port
	localparam int        OPS_TOTAL  = `RAM_WORDS + 9 + 6 + 19 + 2 * N_RAND;
	localparam int        TIMEOUT_NS = OPS_TOTAL * (`RAM_WAIT + 8) * 10 * 4;

	logic      clock;
	logic      reset;
	logic      pb_request = 1'b0;
	bus_req_t  pb_req = '0;
	logic      pb_ready;
	bus_data_t pb_rdata;
	logic      pc_request = 1'b0;
	bus_req_t  pc_req = '0;
	logic      pc_ready;
	bus_data_t pc_rdata;

	// Reference model of the RAM and the I/O block
	bus_data_t model_ram [`RAM_WORDS];
	bus_data_t model_scratch [`IO_REGS] = '{default: '0};
	bus_data_t model_wr_count = '0;

	integer    seed;
	time       b_ready_time;
	time       c_ready_time;
	bus_req_t  rand_b [N_RAND];
	bus_req_t  rand_c [N_RAND];
	int        gap_b [N_RAND];
	int        gap_c [N_RAND];

	clock_gen u_clock (
		.o_clock (clock),
		.o_reset (reset)
	);

	bus_subsystem dut (
		.i_clock      (clock),
		.i_reset      (reset),
		.i_pb_request (pb_request),
		.i_pb_req     (pb_req),
		.o_pb_ready   (pb_ready),
		.o_pb_rdata   (pb_rdata),
		.i_pc_request (pc_request),
		.i_pc_req     (pc_req),
		.o_pc_ready   (pc_ready),
		.o_pc_rdata   (pc_rdata)
	);

	task automatic stop_on_failure();
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_rdata(input string name, input bus_data_t got, input bus_data_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s = %h, expected %h", $time, name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s = %b, expected %b", $time, name, got, exp);
			stop_on_failure();
		end
	endtask

	function automatic bus_req_t make_req(input logic rw, input bus_addr_t addr,
		input bus_data_t wdata);
		return '{rw: rw, addr: addr, wdata: wdata};
	endfunction

	// About a quarter of the traffic lands in the I/O block
	function automatic bus_req_t random_req();
		bus_req_t  r;
		bus_data_t pick;
		pick        = $random(seed);
		r.rw        = pick[0];
		r.addr      = $random(seed);
		r.wdata     = $random(seed);
		r.addr[1:0] = 2'b00;
		r.addr[`IO_SEL_BIT] = pick[1] & pick[2];
		return r;
	endfunction

	// Expected read data
	function automatic bus_data_t ref_read(input bus_addr_t addr);
		int offset;
		offset = int'(addr[4:2]);
		if (!addr[`IO_SEL_BIT])
			return model_ram[addr[9:2]]; // Upper bits alias
		else if (offset < `IO_REGS)
			return model_scratch[offset];
		else if (offset == COUNT_OFS)
			return model_wr_count;
		else
			return '0;
	endfunction

	task automatic apply_write(input bus_req_t req);
		int offset;
		offset = int'(req.addr[4:2]);
		if (!req.addr[`IO_SEL_BIT]) begin
			model_ram[req.addr[9:2]] = req.wdata;
		end else begin
			model_wr_count = model_wr_count + 32'd1; // Any I/O offset counts
			if (offset < `IO_REGS)
				model_scratch[offset] = req.wdata;
		end
	endtask

	task automatic finish_transfer(
		input string     name,
		input logic      requested,
		input bus_req_t  req,
		input bus_data_t rdata
	);
		if (requested !== 1'b1) begin
			$display("Ready pulse for %s with no request pending", name);
			stop_on_failure();
		end else if (req.rw) begin
			apply_write(req);
		end else begin
			check_rdata(name, rdata, ref_read(req.addr));
		end
	endtask

	// Model updated in the order the ready pulses arrive
	always @(negedge clock) begin
		if (!reset && pb_ready)
			finish_transfer("o_pb_rdata", pb_request, pb_req, pb_rdata);
		if (!reset && pc_ready)
			finish_transfer("o_pc_rdata", pc_request, pc_req, pc_rdata);
	end

	task automatic drive_port_b(input bus_req_t req);
		@(negedge clock);
		pb_request <= 1'b1;
		pb_req     <= req;
		@(negedge clock);
		while (pb_ready !== 1'b1)
			@(negedge clock);
		b_ready_time = $time;
		pb_request  <= 1'b0; // Dropped in the ready cycle
	endtask

	task automatic drive_port_c(input bus_req_t req);
		@(negedge clock);
		pc_request <= 1'b1;
		pc_req     <= req;
		@(negedge clock);
		while (pc_ready !== 1'b1)
			@(negedge clock);
		c_ready_time = $time;
		pc_request  <= 1'b0;
	endtask

	initial begin
		seed = 32'h9405_3da5;
		for (int i = 0; i < N_RAND; i++) begin
			rand_b[i] = random_req();
			rand_c[i] = random_req();
			gap_b[i]  = $unsigned($random(seed)) % 4;
			gap_c[i]  = $unsigned($random(seed)) % 4;
		end

		// Readies low through reset and while idle
		@(negedge clock);
		while (reset) begin
			check_flag("o_pb_ready", pb_ready, 1'b0);
			check_flag("o_pc_ready", pc_ready, 1'b0);
			@(negedge clock);
		end
		repeat (8) begin
			check_flag("o_pb_ready", pb_ready, 1'b0);
			check_flag("o_pc_ready", pc_ready, 1'b0);
			@(negedge clock);
		end

		// Fill every RAM word with the ports taking turns
		for (int i = 0; i < `RAM_WORDS; i++) begin
			bus_addr_t a;
			bus_data_t d;
			a = i * 4;
			d = (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
			if (i % 2 == 0)
				drive_port_b(make_req(1'b1, a, d));
			else
				drive_port_c(make_req(1'b1, a, d));
		end

		// One shared memory including aliased addresses
		drive_port_b(make_req(1'b1, 32'h0000_0100, 32'h1234_5678));
		drive_port_c(make_req(1'b0, 32'h0000_0100, '0));
		drive_port_c(make_req(1'b1, 32'h0000_0204, 32'hCAFE_0001));
		drive_port_b(make_req(1'b0, 32'h0000_0204, '0));
		drive_port_b(make_req(1'b1, 32'h0000_0040, 32'hA11A_5001));
		drive_port_c(make_req(1'b0, 32'hFFFE_FC40, '0)); // Same word as 0x40
		drive_port_c(make_req(1'b1, 32'h0002_0440, 32'h0BAD_F00D));
		drive_port_b(make_req(1'b0, 32'h0000_0040, '0));
		drive_port_b(make_req(1'b0, 32'h0000_0044, '0)); // Neighbour untouched

		// Both ports raise a request on the same edge
		for (int k = 0; k < 3; k++) begin
			bus_addr_t a;
			a = (k == 1) ? IO_BASE + 32'h8 : 32'h0000_0080 + k * 4;
			repeat (3) @(negedge clock);
			fork
				drive_port_b(make_req(k != 2, a, 32'h7000_0000 + k));
				drive_port_c(make_req(k == 2, a, 32'h0C00_0000 + k));
			join
			check_flag("o_pb_ready before o_pc_ready",
				b_ready_time < c_ready_time, 1'b1);
		end

		// Scratch registers, write counter, unused offsets
		for (int k = 0; k < `IO_REGS; k++) begin
			drive_port_c(make_req(1'b1, IO_BASE + k * 4, 32'hD00D_0000 + k * 32'h11));
			drive_port_b(make_req(1'b0, IO_BASE + k * 4, '0));
		end
		drive_port_b(make_req(1'b0, IO_BASE + 32'h10, '0));
		drive_port_c(make_req(1'b1, IO_BASE + 32'h10, 32'hFFFF_FFFF));
		drive_port_c(make_req(1'b1, IO_BASE + 32'h14, 32'h5555_AAAA));
		drive_port_b(make_req(1'b1, IO_BASE + 32'h1C, 32'h1234_0000));
		for (int k = 0; k < `IO_REGS; k++)
			drive_port_c(make_req(1'b0, IO_BASE + k * 4, '0));
		drive_port_b(make_req(1'b0, IO_BASE + 32'h14, '0));
		drive_port_c(make_req(1'b0, IO_BASE + 32'h18, '0));
		drive_port_b(make_req(1'b0, IO_BASE + 32'h10, '0));

		// Random traffic from both ports at once
		fork
			for (int i = 0; i < N_RAND; i++) begin
				repeat (gap_b[i]) @(negedge clock);
				drive_port_b(rand_b[i]);
			end
			for (int i = 0; i < N_RAND; i++) begin
				repeat (gap_c[i]) @(negedge clock);
				drive_port_c(rand_c[i]);
			end
		join

		// A stray ready after the last transfer still fails
		repeat (4) @(negedge clock);
		$display("*** PASSED ***");
		$finish;
	end

	// Watchdog sized from the operation count
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout after %0d ns, a transfer never completed", TIMEOUT_NS);
		stop_on_failure();
	end

endmodule

`default_nettype wire

// ==== bus_subsystem.f ====
+incdir+include
logic/bus_pkg.sv
logic/dual_port_arbiter.sv
logic/bus_decoder.sv
logic/ram_slave.sv
logic/io_regs.sv
logic/bus_subsystem.sv
sim/clock_gen.sv
sim/bus_subsystem_sva.sv
sim/bus_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the bus subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f bus_subsystem.f \
	--top-module bus_subsystem_tb \
	-o bus_subsystem_sim

./obj_dir/bus_subsystem_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
